// File: source/mdu_defs.svh
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// operand and result width in bits
`define MDU_XLEN 32

// number of iterative lanes behind the dispatcher
`define MDU_LANES 4

// one shift-add or restoring step per operand bit
`define MDU_ITERS `MDU_XLEN

`endif

// File: source/mdu_pkg.sv
`include "mdu_defs.svh"

package mdu_pkg;

	// operand / result word and the double-width working register
	typedef logic [`MDU_XLEN-1:0] word_t;
	typedef logic [2*`MDU_XLEN-1:0] dword_t;

	// M-extension funct3 encoding
	typedef enum logic [2:0] {
		mul    = 3'b000,
		mulh   = 3'b001,
		mulhsu = 3'b010,
		mulhu  = 3'b011,
		div    = 3'b100,
		divu   = 3'b101,
		rem    = 3'b110,
		remu   = 3'b111
	} mex_funct3_t;

	// round-robin pointer, at least one bit even for a single lane
	localparam int unsigned LANE_IDX_W = (`MDU_LANES > 1) ? $clog2(`MDU_LANES) : 1;
	typedef logic [LANE_IDX_W-1:0] lane_idx_t;

	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_RUN,
		LANE_FIXUP,
		LANE_DONE
	} lane_state_t;

	// four-phase relay sequencer
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,
		HS_ACK,
		HS_DONE
	} hs_state_t;

endpackage

// File: source/mdu_lane_if.sv
`timescale 1ns/1ps

interface mdu_lane_if;
	import mdu_pkg::*;

	// issue side, dispatcher to lane
	logic        issue_req;
	mex_funct3_t issue_op;
	word_t       issue_a;
	word_t       issue_b;
	logic        issue_ack;

	// retire side, lane to collector
	logic  ret_req;
	word_t ret_data;
	logic  ret_ack;

	modport dispatch (
		output issue_req, issue_op, issue_a, issue_b,
		input  issue_ack
	);

	modport lane (
		input  issue_req, issue_op, issue_a, issue_b,
		output issue_ack,
		output ret_req, ret_data,
		input  ret_ack
	);

	modport collect (
		input  ret_req, ret_data,
		output ret_ack
	);

endinterface

// File: source/mdu_dispatch.sv
`timescale 1ns/1ps
`include "mdu_defs.svh"

module mdu_dispatch (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 cmd_req_i,
	input  mdu_pkg::mex_funct3_t cmd_funct3_i,
	input  mdu_pkg::word_t       cmd_rs1_i,
	input  mdu_pkg::word_t       cmd_rs2_i,
	output logic                 cmd_ack_o,
	mdu_lane_if.dispatch         lanes [`MDU_LANES]
);
	import mdu_pkg::*;

	hs_state_t   state;
	lane_idx_t   ptr;
	mex_funct3_t op_q;
	word_t       a_q;
	word_t       b_q;

	logic                  issue_req_w;
	logic [`MDU_LANES-1:0] ack_vec;
	logic                  ack_sel;

	// req is held through REQ and ACK, ack answers from ACK until the lane lets go
	assign issue_req_w = (state == HS_REQ) || (state == HS_ACK);
	assign cmd_ack_o   = (state == HS_ACK) || (state == HS_DONE);
	assign ack_sel     = ack_vec[ptr];

	// operands are broadcast, only the pointed lane sees req
	for (genvar g = 0; g < `MDU_LANES; g++) begin : g_lane
		assign lanes[g].issue_req = issue_req_w && (ptr == lane_idx_t'(g));
		assign lanes[g].issue_op  = op_q;
		assign lanes[g].issue_a   = a_q;
		assign lanes[g].issue_b   = b_q;
		assign ack_vec[g]         = lanes[g].issue_ack;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state <= HS_IDLE;
			ptr   <= '0;
		end else begin
			case (state)
				HS_IDLE: begin
					if (cmd_req_i)
						state <= HS_REQ;
				end
				HS_REQ: begin
					// a busy lane simply never acks, so we stall here
					if (ack_sel)
						state <= HS_ACK;
				end
				HS_ACK: begin
					if (!cmd_req_i)
						state <= HS_DONE;
				end
				HS_DONE: begin
					if (!ack_sel) begin
						state <= HS_IDLE;
						if (ptr == lane_idx_t'(`MDU_LANES - 1))
							ptr <= '0;
						else
							ptr <= ptr + 1'b1;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// command capture
	always_ff @(posedge clk) begin
		if ((state == HS_IDLE) && cmd_req_i) begin
			op_q <= cmd_funct3_i;
			a_q  <= cmd_rs1_i;
			b_q  <= cmd_rs2_i;
		end
	end

	a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_req_w |=> !issue_req_w || $stable({op_q, a_q, b_q}))
		else $error("issued operands changed while issue_req was high");

endmodule

// File: source/mdu_lane.sv
`timescale 1ns/1ps
`include "mdu_defs.svh"

module mdu_lane (
	input logic     clk,
	input logic     rst_n_i,
	mdu_lane_if.lane lane
);
	import mdu_pkg::*;

	localparam int unsigned XLEN  = `MDU_XLEN;
	localparam int unsigned CNT_W = $clog2(`MDU_ITERS + 1);

	lane_state_t      state;
	logic [CNT_W-1:0] cnt;
	logic             issue_ack_q;
	logic             ret_req_q;

	// payload
	mex_funct3_t op_q;
	word_t       a_q;
	word_t       b_q;
	dword_t      acc;
	logic        neg_q;
	logic        neg_r;
	logic        div_zero;
	logic        ovf;
	word_t       ret_data_q;

	logic            signed_a;
	logic            signed_b;
	logic            a_neg;
	logic            b_neg;
	word_t           a_mag;
	word_t           b_mag;
	logic [XLEN:0]   mul_sum;
	logic [XLEN+1:0] div_diff;
	dword_t          prod;
	word_t           quo;
	word_t           rmd;
	word_t           result;

	assign lane.issue_ack = issue_ack_q;
	assign lane.ret_req   = ret_req_q;
	assign lane.ret_data  = ret_data_q;

	// operand setup, for mulhsu only rs1 is signed
	always_comb begin
		signed_a = (op_q == mulh) || (op_q == mulhsu) || (op_q == div) || (op_q == rem);
		signed_b = (op_q == mulh) || (op_q == div) || (op_q == rem);
		a_neg    = signed_a && a_q[XLEN-1];
		b_neg    = signed_b && b_q[XLEN-1];
		a_mag    = a_neg ? -a_q : a_q;
		b_mag    = b_neg ? -b_q : b_q;
	end

	// one step of each algorithm, acc holds {hi, lo}
	always_comb begin
		mul_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + {1'b0, b_q & {XLEN{acc[0]}}};
		// shifted remainder needs XLEN+1 bits when the divisor is above 2^(XLEN-1)
		div_diff = {1'b0, acc[2*XLEN-1:XLEN-1]} - {2'b00, b_q};
	end

	// sign fix-up and result select
	always_comb begin
		prod = neg_q ? -acc : acc;
		quo  = acc[XLEN-1:0];
		rmd  = acc[2*XLEN-1:XLEN];
		case (op_q)
			mul:                 result = prod[XLEN-1:0];
			mulh, mulhsu, mulhu: result = prod[2*XLEN-1:XLEN];
			div, divu: begin
				if (div_zero)
					result = '1;
				else if (ovf)
					result = a_q;
				else
					result = neg_q ? -quo : quo;
			end
			rem, remu: begin
				if (div_zero)
					result = a_q;
				else if (ovf)
					result = '0;
				else
					result = neg_r ? -rmd : rmd;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state       <= LANE_IDLE;
			cnt         <= '0;
			issue_ack_q <= 1'b0;
			ret_req_q   <= 1'b0;
		end else begin
			if (issue_ack_q && !lane.issue_req)
				issue_ack_q <= 1'b0;
			case (state)
				LANE_IDLE: begin
					if (lane.issue_req && !issue_ack_q) begin
						issue_ack_q <= 1'b1;
						cnt         <= '0;
						state       <= LANE_RUN;
					end
				end
				LANE_RUN: begin
					// cnt 0 is the setup cycle, 1..ITERS are the steps
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`MDU_ITERS))
						state <= LANE_FIXUP;
				end
				LANE_FIXUP: begin
					ret_req_q <= 1'b1;
					state     <= LANE_DONE;
				end
				LANE_DONE: begin
					// busy until the collector has dropped its ack
					if (ret_req_q && lane.ret_ack)
						ret_req_q <= 1'b0;
					else if (!ret_req_q && !lane.ret_ack)
						state <= LANE_IDLE;
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			LANE_IDLE: begin
				if (lane.issue_req && !issue_ack_q) begin
					op_q <= lane.issue_op;
					a_q  <= lane.issue_a;
					b_q  <= lane.issue_b;
				end
			end
			LANE_RUN: begin
				if (cnt == '0) begin
					acc      <= {{XLEN{1'b0}}, a_mag};
					b_q      <= b_mag;
					neg_q    <= a_neg ^ b_neg;
					neg_r    <= a_neg;
					div_zero <= (b_q == '0);
					// most negative value over minus one
					ovf      <= op_q[2] && signed_b && (&b_q) &&
					            (a_q == {1'b1, {(XLEN-1){1'b0}}});
				end else if (op_q[2]) begin
					if (!div_diff[XLEN+1])
						acc <= {div_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
					else
						acc <= {acc[2*XLEN-2:0], 1'b0};
				end else begin
					acc <= {mul_sum, acc[XLEN-1:1]};
				end
			end
			LANE_FIXUP: ret_data_q <= result;
			default: ;
		endcase
	end

	a_ret_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		lane.ret_req && !lane.ret_ack |=> lane.ret_req)
		else $error("ret_req dropped before ret_ack");

	// fixed latency from issue ack to retire request
	a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(lane.issue_ack) |-> ##(`MDU_ITERS + 2) $rose(lane.ret_req))
		else $error("lane latency differs from ITERS + 2");

endmodule

// File: source/mdu_collect.sv
`timescale 1ns/1ps
`include "mdu_defs.svh"

module mdu_collect (
	input  logic           clk,
	input  logic           rst_n_i,
	mdu_lane_if.collect    lanes [`MDU_LANES],
	output logic           res_req_o,
	output mdu_pkg::word_t res_data_o,
	input  logic           res_ack_i
);
	import mdu_pkg::*;

	hs_state_t state;
	lane_idx_t ptr;
	word_t     res_data_q;

	logic                  ret_ack_w;
	logic [`MDU_LANES-1:0] req_vec;
	word_t                 data_arr [`MDU_LANES];
	logic                  req_sel;

	assign res_req_o  = (state == HS_REQ) || (state == HS_ACK);
	assign ret_ack_w  = (state == HS_ACK) || (state == HS_DONE);
	assign res_data_o = res_data_q;
	assign req_sel    = req_vec[ptr];

	for (genvar g = 0; g < `MDU_LANES; g++) begin : g_lane
		assign req_vec[g]       = lanes[g].ret_req;
		assign data_arr[g]      = lanes[g].ret_data;
		assign lanes[g].ret_ack = ret_ack_w && (ptr == lane_idx_t'(g));
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state <= HS_IDLE;
			ptr   <= '0;
		end else begin
			case (state)
				HS_IDLE: begin
					// other lanes may finish first, they wait their turn
					if (req_sel)
						state <= HS_REQ;
				end
				HS_REQ: begin
					if (res_ack_i)
						state <= HS_ACK;
				end
				HS_ACK: begin
					if (!req_sel)
						state <= HS_DONE;
				end
				HS_DONE: begin
					if (!res_ack_i) begin
						state <= HS_IDLE;
						if (ptr == lane_idx_t'(`MDU_LANES - 1))
							ptr <= '0;
						else
							ptr <= ptr + 1'b1;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// result capture
	always_ff @(posedge clk) begin
		if ((state == HS_IDLE) && req_sel)
			res_data_q <= data_arr[ptr];
	end

	a_res_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		res_req_o |=> !res_req_o || $stable(res_data_o))
		else $error("res_data_o changed while res_req_o was high");

endmodule

// File: source/mdu_top.sv
`timescale 1ns/1ps
`include "mdu_defs.svh"

module mdu_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 cmd_req_i,
	input  mdu_pkg::mex_funct3_t cmd_funct3_i,
	input  mdu_pkg::word_t       cmd_rs1_i,
	input  mdu_pkg::word_t       cmd_rs2_i,
	output logic                 cmd_ack_o,
	output logic                 res_req_o,
	output mdu_pkg::word_t       res_data_o,
	input  logic                 res_ack_i
);

	// one bus per lane, shared by dispatcher and collector
	mdu_lane_if lane_bus [`MDU_LANES] ();

	mdu_dispatch u_dispatch (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.cmd_req_i    (cmd_req_i),
		.cmd_funct3_i (cmd_funct3_i),
		.cmd_rs1_i    (cmd_rs1_i),
		.cmd_rs2_i    (cmd_rs2_i),
		.cmd_ack_o    (cmd_ack_o),
		.lanes        (lane_bus)
	);

	for (genvar g = 0; g < `MDU_LANES; g++) begin : g_lane
		mdu_lane u_lane (
			.clk     (clk),
			.rst_n_i (rst_n_i),
			.lane    (lane_bus[g])
		);
	end

	mdu_collect u_collect (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.lanes      (lane_bus),
		.res_req_o  (res_req_o),
		.res_data_o (res_data_o),
		.res_ack_i  (res_ack_i)
	);

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// reset held low for three rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// File: sim/mdu_tb.sv
`timescale 1ns/1ps
`include "mdu_defs.svh"

module mdu_tb;
	import mdu_pkg::*;

	localparam int N_CMDS         = 200;
	localparam int BURST_CMDS     = 40;
	localparam int SLOW_FIRST     = 80;
	localparam int SLOW_LAST      = 120;
	localparam int SLOW_EXTRA     = 40;
	localparam int TIMEOUT_CYCLES = N_CMDS * (`MDU_ITERS + 40) + 100;
	localparam logic [31:0] SEED  = 32'h26d6;

	logic        clk;
	logic        rst_n;
	logic        cmd_req = 1'b0;
	mex_funct3_t cmd_funct3 = mul;
	word_t       cmd_rs1 = '0;
	word_t       cmd_rs2 = '0;
	logic        cmd_ack;
	logic        res_req;
	word_t       res_data;
	logic        res_ack = 1'b0;

	logic [31:0] lfsr = SEED;
	int          errors = 0;
	int          results = 0;
	int          issued = 0;
	int          retired = 0;
	int          cycles = 0;
	logic        cmd_ack_q = 1'b0;
	logic        res_req_q = 1'b0;
	word_t       exp_q [$];

	// pre-drawn stimulus
	mex_funct3_t op_arr [N_CMDS];
	word_t       a_arr [N_CMDS];
	word_t       b_arr [N_CMDS];
	int          req_dly [N_CMDS];
	int          ack_dly [N_CMDS];

	tb_clock u_clock (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	mdu_top dut_i (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.cmd_req_i    (cmd_req),
		.cmd_funct3_i (cmd_funct3),
		.cmd_rs1_i    (cmd_rs1),
		.cmd_rs2_i    (cmd_rs2),
		.cmd_ack_o    (cmd_ack),
		.res_req_o    (res_req),
		.res_data_o   (res_data),
		.res_ack_i    (res_ack)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// random, zero, minus one or most negative
	task automatic pick_operand(output word_t v);
		logic [31:0] cls;
		take_bits(2, cls);
		case (cls[1:0])
			2'd0: take_bits(32, v);
			2'd1: v = '0;
			2'd2: v = '1;
			default: v = 32'h8000_0000;
		endcase
	endtask

	task automatic make_stimulus();
		logic [31:0] bits;
		for (int i = 0; i < N_CMDS; i++) begin
			take_bits(3, bits);
			op_arr[i] = mex_funct3_t'(bits[2:0]);
			pick_operand(a_arr[i]);
			pick_operand(b_arr[i]);
			take_bits(3, bits);
			// first commands go back to back
			req_dly[i] = (i < BURST_CMDS) ? 0 : int'(bits[2:0]);
			take_bits(3, bits);
			ack_dly[i] = int'(bits[2:0]);
			if (i >= SLOW_FIRST && i < SLOW_LAST)
				ack_dly[i] = ack_dly[i] + SLOW_EXTRA;
		end
	endtask

	// RISC-V M rules on 64-bit arithmetic
	function automatic word_t model_result(input mex_funct3_t op, input word_t a, input word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        ua;
		logic [63:0]        ub;
		logic [63:0]        p;
		word_t              r;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'h0, a};
		ub = {32'h0, b};
		p  = '0;
		case (op)
			mul: begin
				p = ua * ub;
				r = p[31:0];
			end
			mulh: begin
				p = sa * sb;
				r = p[63:32];
			end
			mulhsu: begin
				p = sa * $signed(ub);
				r = p[63:32];
			end
			mulhu: begin
				p = ua * ub;
				r = p[63:32];
			end
			div: begin
				if (b == '0)
					r = '1;
				else if (a == 32'h8000_0000 && b == '1)
					r = a;
				else begin
					p = sa / sb;
					r = p[31:0];
				end
			end
			divu: begin
				p = ua / ub;
				r = (b == '0) ? '1 : p[31:0];
			end
			rem: begin
				if (b == '0)
					r = a;
				else if (a == 32'h8000_0000 && b == '1)
					r = '0;
				else begin
					p = sa % sb;
					r = p[31:0];
				end
			end
			remu: begin
				p = ua % ub;
				r = (b == '0) ? a : p[31:0];
			end
		endcase
		return r;
	endfunction

	task automatic compare_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic send_commands();
		for (int i = 0; i < N_CMDS; i++) begin
			repeat (req_dly[i]) @(posedge clk);
			cmd_funct3 <= op_arr[i];
			cmd_rs1    <= a_arr[i];
			cmd_rs2    <= b_arr[i];
			cmd_req    <= 1'b1;
			@(posedge clk);
			while (!cmd_ack)
				@(posedge clk);
			exp_q.push_back(model_result(op_arr[i], a_arr[i], b_arr[i]));
			cmd_req <= 1'b0;
			@(posedge clk);
			while (cmd_ack)
				@(posedge clk);
		end
	endtask

	task automatic receive_results();
		for (int i = 0; i < N_CMDS; i++) begin
			@(posedge clk);
			while (!res_req)
				@(posedge clk);
			if (exp_q.size() == 0) begin
				errors++;
				$display("result arrived at %0t with no command outstanding", $time);
			end else
				compare_value("res_data_o", res_data, exp_q.pop_front());
			repeat (ack_dly[i]) @(posedge clk);
			res_ack <= 1'b1;
			@(posedge clk);
			while (res_req)
				@(posedge clk);
			res_ack <= 1'b0;
			retired <= retired + 1;
		end
	endtask

	// handshake rules seen from outside
	always @(posedge clk) begin
		if (rst_n) begin
			if (cmd_ack && !cmd_ack_q) begin
				issued = issued + 1;
				if (issued - retired > `MDU_LANES) begin
					errors++;
					$display("command accepted at %0t while all lanes held results", $time);
				end
			end
			// every rising res_req_o is one result
			if (res_req && !res_req_q)
				results = results + 1;
			if (res_req_q && !res_req && !res_ack) begin
				errors++;
				$display("res_req_o dropped at %0t before res_ack_i was raised", $time);
			end
		end
		cmd_ack_q = cmd_ack;
		res_req_q = res_req;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d results", cycles, results, N_CMDS);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		make_stimulus();
		wait (rst_n);
		@(posedge clk);
		compare_value("cmd_ack_o", word_t'(cmd_ack), '0);
		compare_value("res_req_o", word_t'(res_req), '0);
		fork
			send_commands();
			receive_results();
		join
		// nothing more may come out
		repeat (`MDU_ITERS + 10) @(posedge clk);
		if (res_req) begin
			errors++;
			$display("an extra result appeared after all commands were answered");
		end
		if (results != N_CMDS || exp_q.size() != 0) begin
			errors++;
			$display("%0d results for %0d commands", results, N_CMDS);
		end
		$display("commands %0d, results %0d, errors %0d", N_CMDS, results, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: all.f
+incdir+source
source/mdu_pkg.sv
source/mdu_lane_if.sv
source/mdu_dispatch.sv
source/mdu_lane.sv
source/mdu_collect.sv
source/mdu_top.sv
sim/tb_clock.sv
sim/mdu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mdu_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := === FAIL ===
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
